// File: verilog/strm_cfg_pkg.sv
// ==================================================
// Cache geometry for the streaming read channel
// ==================================================

package strm_cfg_pkg;

  localparam int adr_bits   = 32;   // Byte address width on both buses
  localparam int line_bits  = 256;  // One line is a full 32 byte bus beat
  localparam int line_bytes = 32;
  localparam int blk_lines  = 64;   // Lines per cache block, 2 KB per block
  localparam int num_blks   = 8;    // Direct mapped, one way

  // Address split, low to high
  localparam int off_bits   = $clog2(line_bytes);      // Bits 4..0 select a byte in the line
  localparam int lidx_bits  = $clog2(blk_lines);       // Bits 10..5 select the line in a block
  localparam int bidx_bits  = $clog2(num_blks);        // Bits 13..11 select the block
  localparam int lidx_lsb   = off_bits;
  localparam int bidx_lsb   = lidx_lsb + lidx_bits;
  localparam int tag_lsb    = bidx_lsb + bidx_bits;
  localparam int tag_bits   = adr_bits - tag_lsb;      // Bits 31..14 are kept as the tag

  // The data RAM holds every line of every block
  localparam int data_depth = blk_lines * num_blks;

  typedef logic [line_bits-1:0] line_t;

  // One entry per block in the tag RAM
  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

  typedef logic [lidx_bits+bidx_bits-1:0] line_idx_t;  // Data RAM address, block then line
  typedef logic [bidx_bits-1:0]           blk_idx_t;   // Tag RAM address

endpackage

// File: verilog/strm_bus_pkg.sv
// ==================================================
// Wishbone classic read bus, 256 bit data
// ==================================================

package strm_bus_pkg;

  // Master to slave half of the bus
  // The same layout is used by the requester and by the fill engine
  // Write enable and byte selects are absent since the channel only reads
  typedef struct packed {
    logic                              cyc;  // Bus cycle in progress
    logic                              stb;  // Valid transfer request
    logic [strm_cfg_pkg::adr_bits-1:0] adr;  // Byte address, line aligned in use
  } wb_req_t;

  // Slave to master half of the bus
  // Ack is a single cycle strobe and dat is only meaningful while it is high
  typedef struct packed {
    logic                ack;
    strm_cfg_pkg::line_t dat;
  } wb_rsp_t;

endpackage

// File: verilog/strm_line_ram.sv
`timescale 1ns/1ps

// Simple dual port RAM on a single clock
// Write is synchronous and read data is registered, so a read takes one cycle
// A read and a write to the same address in one cycle return the old contents
module strm_line_ram #(
  parameter type payload_t = logic,
  parameter int  depth     = 8
) (
  input  logic                     rclk,
  input  logic                     wr,
  input  logic [$clog2(depth)-1:0] wadr,
  input  payload_t                 wdat,
  input  logic                     rd,
  input  logic [$clog2(depth)-1:0] radr,
  output payload_t                 rdat
);

  payload_t mem [depth];  // Storage array, contents start undefined

  always_ff @(posedge rclk) begin
    if (wr) begin
      mem[wadr] <= wdat;
    end
    if (rd) begin
      rdat <= mem[radr];  // Output holds its value while rd is low
    end
  end

endmodule

// File: verilog/strm_read_cache.sv
`timescale 1ns/1ps

module strm_read_cache (
  input  logic                     rclk,
  input  logic                     rst,
  input  strm_bus_pkg::wb_req_t    req,
  output strm_bus_pkg::wb_rsp_t    rsp,
  input  logic                     inv,
  input  logic [31:0]              inv_adr,
  output logic                     fill_start,
  output logic [31:0]              fill_adr,
  input  logic                     line_wr,
  input  strm_cfg_pkg::line_idx_t  line_idx,
  input  strm_cfg_pkg::line_t      line_dat,
  input  logic                     tag_wr,
  input  strm_cfg_pkg::tag_entry_t tag_dat,
  input  logic                     fill_done
);
  import strm_cfg_pkg::*;
  import strm_bus_pkg::*;

  typedef enum logic [2:0] {
    st_walk,     // Clearing the tag RAM after reset
    st_idle,
    st_lookup,   // RAM reads of the held address
    st_compare,
    st_miss,     // Waiting on the fill engine
    st_reread
  } state_t;

  state_t     state;
  wb_req_t    reqh;      // Request held until it is answered
  blk_idx_t   walk_cnt;
  logic       inv_wr;    // Invalidate write, one cycle after inv
  logic       inv_wr_q;
  blk_idx_t   inv_idx;
  logic       req_take;
  logic       ram_rd;
  line_idx_t  rd_line;
  blk_idx_t   rd_blk;
  logic       tag_we;
  blk_idx_t   tag_wadr;
  tag_entry_t tag_wdat;
  tag_entry_t tag_q;
  line_t      line_q;
  logic       hit;
  logic       tag_stale;

  // ==================================================
  // Request capture and RAM read side
  // ==================================================

  // The ack cycle is a compare cycle, so idle never sees the answered request
  assign req_take = (state == st_idle) && req.cyc && req.stb;

  always_ff @(posedge rclk) begin
    if (req_take) begin
      reqh <= req;
    end
  end

  assign ram_rd   = (state == st_lookup) || (state == st_reread);
  assign rd_line  = reqh.adr[lidx_lsb +: lidx_bits + bidx_bits];  // Address bits 13..5
  assign rd_blk   = reqh.adr[bidx_lsb +: bidx_bits];
  assign fill_adr = {reqh.adr[adr_bits-1:bidx_lsb], {bidx_lsb{1'b0}}};  // Block base

  assign hit = tag_q.valid && (tag_q.tag == reqh.adr[tag_lsb +: tag_bits]);

  // A tag read that overlapped an invalidate write, or a compare that does, is not trusted
  assign tag_stale = inv_wr || inv_wr_q;

  // ==================================================
  // Tag RAM write port
  // ==================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      inv_wr   <= 1'b0;
      inv_wr_q <= 1'b0;
    end else begin
      inv_wr   <= inv;
      inv_wr_q <= inv_wr;
    end
  end

  always_ff @(posedge rclk) begin
    if (inv) begin
      inv_idx <= inv_adr[bidx_lsb +: bidx_bits];
    end
  end

  // Reset walk wins, then invalidate, and the fill engine comes last
  always_comb begin
    if (state == st_walk) begin
      tag_we   = 1'b1;
      tag_wadr = walk_cnt;
      tag_wdat = '0;
    end else if (inv_wr) begin
      tag_we   = 1'b1;
      tag_wadr = inv_idx;
      tag_wdat = '0;  // Valid clear, tag is don't care
    end else begin
      tag_we   = tag_wr;
      tag_wadr = line_idx[lidx_bits +: bidx_bits];  // Block of the line being filled
      tag_wdat = tag_dat;
    end
  end

  // ==================================================
  // Control
  // ==================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      state      <= st_walk;
      walk_cnt   <= '0;
      fill_start <= 1'b0;
    end else begin
      fill_start <= 1'b0;  // Single cycle strobe
      case (state)
        st_walk: begin
          walk_cnt <= walk_cnt + 1'b1;
          if (walk_cnt == blk_idx_t'(num_blks - 1)) begin
            state <= st_idle;
          end
        end
        st_idle:    if (req_take) state <= st_lookup;
        st_lookup:  state <= st_compare;
        st_compare: begin
          if (tag_stale) begin
            state <= st_reread;  // Invalidate has priority, look again
          end else if (hit) begin
            state <= st_idle;
          end else begin
            fill_start <= 1'b1;
            state      <= st_miss;
          end
        end
        st_miss:    if (fill_done) state <= st_reread;
        st_reread:  state <= st_compare;
        default:    state <= st_walk;
      endcase
    end
  end

  // Ack rides on the compare cycle with the line straight from the data RAM
  always_comb begin
    rsp.ack = (state == st_compare) && !tag_stale && hit;
    rsp.dat = line_q;
  end

  strm_line_ram #(.payload_t(line_t), .depth(data_depth)) data_ram_i (
    .rclk (rclk),
    .wr   (line_wr),
    .wadr (line_idx),
    .wdat (line_dat),
    .rd   (ram_rd),
    .radr (rd_line),
    .rdat (line_q)
  );

  strm_line_ram #(.payload_t(tag_entry_t), .depth(num_blks)) tag_ram_i (
    .rclk (rclk),
    .wr   (tag_we),
    .wadr (tag_wadr),
    .wdat (tag_wdat),
    .rd   (ram_rd),
    .radr (rd_blk),
    .rdat (tag_q)
  );

endmodule

// File: verilog/strm_fill_engine.sv
`timescale 1ns/1ps

// Fetches one whole block from backing memory into the cache
module strm_fill_engine (
  input  logic                     rclk,
  input  logic                     rst,
  input  logic                     fill_start,
  input  logic [31:0]              fill_adr,
  output strm_bus_pkg::wb_req_t    mem_req,
  input  strm_bus_pkg::wb_rsp_t    mem_rsp,
  output logic                     line_wr,
  output strm_cfg_pkg::line_idx_t  line_idx,
  output strm_cfg_pkg::line_t      line_dat,
  output logic                     tag_wr,
  output strm_cfg_pkg::tag_entry_t tag_dat,
  output logic                     fill_done
);
  import strm_cfg_pkg::*;

  logic                         busy;       // Memory bus cycle held open
  logic [adr_bits-1:bidx_lsb]   blk_base;   // Address bits 31..11 of the block
  logic [lidx_bits-1:0]         line_cnt;   // Next line to fetch within the block
  logic                         line_ack;
  logic                         last_line;

  // ==================================================
  // Sequencing
  // ==================================================

  assign line_ack  = busy && mem_rsp.ack;
  assign last_line = (line_cnt == lidx_bits'(blk_lines - 1));

  always_ff @(posedge rclk) begin
    if (rst) begin
      busy      <= 1'b0;
      line_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= tag_wr;  // Done follows the tag write by one cycle
      if (!busy && fill_start) begin
        busy     <= 1'b1;
        line_cnt <= '0;
      end else if (line_ack) begin
        line_cnt <= line_cnt + 1'b1;  // Wraps back to zero after the last line
        if (last_line) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Block base is only loaded when a fill starts
  always_ff @(posedge rclk) begin
    if (!busy && fill_start) begin
      blk_base <= fill_adr[adr_bits-1:bidx_lsb];
    end
  end

  // ==================================================
  // Memory bus and cache write side
  // ==================================================

  // Cyc and stb stay up across all 64 lines, the address steps on each ack
  always_comb begin
    mem_req.cyc = busy;
    mem_req.stb = busy;
    mem_req.adr = {blk_base, line_cnt, {off_bits{1'b0}}};
  end

  // Acked data goes straight into the data RAM
  assign line_wr  = line_ack;
  assign line_idx = {blk_base[bidx_lsb +: bidx_bits], line_cnt};
  assign line_dat = mem_rsp.dat;

  // Tag goes in with the final line so a lookup never sees a half filled block
  assign tag_wr = line_ack && last_line;

  always_comb begin
    tag_dat.valid = 1'b1;
    tag_dat.tag   = blk_base[adr_bits-1:tag_lsb];
  end

endmodule

// File: verilog/strm_read_channel.sv
`timescale 1ns/1ps

// One read channel, the cache in front of the block fill engine
module strm_read_channel (
  input  logic                  rclk,
  input  logic                  rst,
  input  strm_bus_pkg::wb_req_t req,
  output strm_bus_pkg::wb_rsp_t rsp,
  input  logic                  inv,
  input  logic [31:0]           inv_adr,
  output strm_bus_pkg::wb_req_t mem_req,
  input  strm_bus_pkg::wb_rsp_t mem_rsp
);
  import strm_cfg_pkg::*;

  // ==================================================
  // Cache to fill engine
  // ==================================================

  logic                fill_start;  // Miss detected, fetch the block
  logic [adr_bits-1:0] fill_adr;
  logic                line_wr;     // Data RAM write from the fill
  line_idx_t           line_idx;
  line_t               line_dat;
  logic                tag_wr;      // Tag RAM write with the last line
  tag_entry_t          tag_dat;
  logic                fill_done;

  strm_read_cache cache_i (
    .rclk       (rclk),
    .rst        (rst),
    .req        (req),
    .rsp        (rsp),
    .inv        (inv),
    .inv_adr    (inv_adr),
    .fill_start (fill_start),
    .fill_adr   (fill_adr),
    .line_wr    (line_wr),
    .line_idx   (line_idx),
    .line_dat   (line_dat),
    .tag_wr     (tag_wr),
    .tag_dat    (tag_dat),
    .fill_done  (fill_done)
  );

  strm_fill_engine fill_i (
    .rclk       (rclk),
    .rst        (rst),
    .fill_start (fill_start),
    .fill_adr   (fill_adr),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .line_wr    (line_wr),
    .line_idx   (line_idx),
    .line_dat   (line_dat),
    .tag_wr     (tag_wr),
    .tag_dat    (tag_dat),
    .fill_done  (fill_done)
  );

endmodule

// File: verification/strm_mem_model.sv
`timescale 1ns/1ps

// Backing memory seen by the fill engine
// Each line reads back as a pattern of its own address, so nothing is stored
module strm_mem_model (
  input  logic                  rclk,
  input  logic                  rst,
  input  strm_bus_pkg::wb_req_t req,
  output strm_bus_pkg::wb_rsp_t rsp
);
  import strm_cfg_pkg::*;

  logic [1:0] wait_cnt;  // Wait states still to pass before the next ack

  // Word k of a line is the line base address plus 4 times k
  function automatic line_t line_at(input logic [31:0] adr);
    line_t       l;
    logic [31:0] base;
    base = {adr[31:5], 5'b0};
    for (int k = 0; k < 8; k++) begin
      l[k*32 +: 32] = base + 32'(4 * k);
    end
    return l;
  endfunction

  always_ff @(posedge rclk) begin
    if (rst) begin
      rsp.ack  <= 1'b0;
      rsp.dat  <= '0;
      wait_cnt <= '0;
    end else begin
      rsp.ack <= 1'b0;  // Single cycle strobe
      // The ack cycle itself is skipped so one request never gets two acks
      if (req.cyc && req.stb && !rsp.ack) begin
        if (wait_cnt == 2'd0) begin
          rsp.ack  <= 1'b1;
          rsp.dat  <= line_at(req.adr);
          wait_cnt <= 2'($urandom % 4);  // Zero to three wait states for the next line
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

// File: verification/strm_read_channel_tb.sv
`timescale 1ns/1ps

module strm_read_channel_tb;
  import strm_cfg_pkg::*;
  import strm_bus_pkg::*;

  localparam int wait_limit = 1000;  // A fill with the slowest memory needs about 330 cycles

  logic                rclk = 1'b0;
  logic                rst;
  wb_req_t             req;
  wb_rsp_t             rsp;
  logic                inv;
  logic [31:0]         inv_adr;
  wb_req_t             mem_req;
  wb_rsp_t             mem_rsp;

  int                  errors = 0;
  int                  checks = 0;
  int                  tests = 0;
  int                  bad_tests = 0;
  int                  mem_acks = 0;    // Acked memory lines seen so far
  int                  stray_acks = 0;  // Acked lines outside the block being read
  int                  fills = 0;       // Memory bus cycles opened by the fill engine
  int                  misses = 0;      // Misses predicted by the reference model
  logic                cyc_prev = 1'b0;
  logic                hung = 1'b0;
  logic [31:11]        exp_blk = '0;    // Block the current read may fetch
  logic [num_blks-1:0] ref_valid = '0;  // Reference copy of the tag RAM
  logic [tag_bits-1:0] ref_tag [num_blks];

  always #5 rclk = ~rclk;

  strm_read_channel dut_i (
    .rclk    (rclk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .inv     (inv),
    .inv_adr (inv_adr),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  strm_mem_model mem_i (
    .rclk (rclk),
    .rst  (rst),
    .req  (mem_req),
    .rsp  (mem_rsp)
  );

  // ==================================================
  // Memory port monitor and run limit
  // ==================================================

  always @(negedge rclk) begin
    if (mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
      mem_acks++;
      if (mem_req.adr[31:11] != exp_blk) stray_acks++;
    end
    if (mem_req.cyc && !cyc_prev) fills++;  // Cyc stays up over all 64 lines of a fill
    cyc_prev = mem_req.cyc;
  end

  // A read that never acks ends the run here
  always @(posedge rclk) begin
    if (hung) begin
      $display("TEST FAILED");
      $finish;
    end
  end

  // Word k of a line is the line base address plus 4 times k
  function automatic line_t rule_line(input logic [31:0] adr);
    line_t       l;
    logic [31:0] base;
    base = {adr[31:5], 5'b0};
    for (int k = 0; k < 8; k++) begin
      l[k*32 +: 32] = base + 32'(4 * k);
    end
    return l;
  endfunction

  // ==================================================
  // Bus tasks
  // ==================================================

  task automatic read_line(input logic [31:0] adr);
    line_t    exp_line;
    blk_idx_t b;
    logic     miss;
    int       acks_at_start;
    int       stray_at_start;
    int       cnt;
    b            = adr[13:11];
    miss         = !ref_valid[b] || (ref_tag[b] != adr[31:14]);  // Predict before the update
    ref_valid[b] = 1'b1;
    ref_tag[b]   = adr[31:14];
    if (miss) misses++;
    exp_line       = rule_line(adr);
    exp_blk        = adr[31:11];
    acks_at_start  = mem_acks;
    stray_at_start = stray_acks;
    cnt            = 0;
    @(posedge rclk);
    req <= '{cyc: 1'b1, stb: 1'b1, adr: adr};
    do begin
      @(negedge rclk);
      cnt++;
    end while (!rsp.ack && cnt < wait_limit);
    if (!rsp.ack) begin
      $display("Timeout, no ack on the requester port for address %h", adr);
      errors++;
      hung = 1'b1;
    end else begin
      checks += 3;
      assert (rsp.dat == exp_line) else begin
        $display("ERR rsp.dat got %h exp %h", rsp.dat, exp_line);
        errors++;
      end
      assert (mem_acks - acks_at_start == (miss ? blk_lines : 0)) else begin
        $display("ERR mem_acks got %h exp %h", mem_acks - acks_at_start,
                 miss ? blk_lines : 0);
        errors++;
      end
      assert (stray_acks == stray_at_start) else begin
        $display("Memory was read outside block %h during the read of %h", exp_blk, adr);
        errors++;
      end
      if (!miss) begin
        checks++;
        // The first negedge falls before the edge that samples the request
        assert (cnt - 1 == 2) else begin
          $display("ERR ack_latency got %h exp %h", cnt - 1, 2);
          errors++;
        end
      end
      @(posedge rclk);
      req <= '0;  // Requester drops cyc and stb for at least one cycle
    end
  endtask

  task automatic invalidate(input logic [31:0] adr);
    @(posedge rclk);
    inv     <= 1'b1;
    inv_adr <= adr;
    @(posedge rclk);
    inv     <= 1'b0;
    ref_valid[adr[13:11]] = 1'b0;
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    tests++;
    if (errors != errs_at_start) bad_tests++;
    $display("test %-16s %s", name, (errors == errs_at_start) ? "ok" : "errors");
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    logic [31:0] a;
    int          errs;
    int          fills_at_start;
    int          misses_at_start;
    void'($urandom(32'hd306834f));
    rst     = 1'b1;
    req     = '0;
    inv     = 1'b0;
    inv_adr = '0;
    repeat (3) @(posedge rclk);
    rst <= 1'b0;

    errs = errors;
    @(negedge rclk);
    checks++;
    assert (!rsp.ack && !mem_req.cyc) else begin
      $display("ERR rsp.ack/mem_req.cyc got %h exp %h", {rsp.ack, mem_req.cyc}, 2'b00);
      errors++;
    end
    repeat (num_blks + 2) @(posedge rclk);  // Tag RAM walk after reset
    close_test("reset_state", errs);

    errs = errors;
    read_line(32'h0004_1a60);  // Tag 0x10, block 3, cold miss
    close_test("first_miss", errs);

    errs = errors;
    read_line(32'h0004_1f24);  // Other line of the same block
    close_test("same_block_hit", errs);

    errs = errors;
    read_line(32'h0008_1a60);  // Tag 0x20 evicts block 3
    read_line(32'h0004_1a60);  // Old block comes back with a new fill
    close_test("tag_conflict", errs);

    errs = errors;
    read_line(32'h0004_1a80);
    invalidate(32'h0004_1800);
    read_line(32'h0004_1a80);  // Refetch after the valid bit is gone
    close_test("invalidate", errs);

    errs            = errors;
    fills_at_start  = fills;
    misses_at_start = misses;
    for (int i = 0; i < 200; i++) begin
      a = {18'h00010 + 18'($urandom % 3), 3'($urandom % 4), 6'($urandom), 5'($urandom)};
      if ($urandom % 16 == 0) begin
        invalidate({18'h0, 3'($urandom % 4), 11'h0});  // Tag bits play no part here
      end
      read_line(a);
    end
    checks++;
    assert (fills - fills_at_start == misses - misses_at_start) else begin
      $display("ERR fills got %h exp %h", fills - fills_at_start, misses - misses_at_start);
      errors++;
    end
    close_test("random_reads", errs);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, bad_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/strm_cfg_pkg.sv
verilog/strm_bus_pkg.sv
verilog/strm_line_ram.sv
verilog/strm_read_cache.sv
verilog/strm_fill_engine.sv
verilog/strm_read_channel.sv
verification/strm_mem_model.sv
verification/strm_read_channel_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read channel testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module strm_read_channel_tb -f verilog.f -o sim
./obj_dir/sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
